//--- source/mem_pkg.sv
package mem_pkg;

    // ==================================================
    // widths with a meaning
    // ==================================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [7:0]  byte_t;

    // access length, value equals the byte count
    typedef enum logic [2:0] {
        size_byte = 3'd1,
        size_half = 3'd2,
        size_word = 3'd4
    } size_e;

    // per-cycle decision of the data cache
    typedef enum logic [1:0] {
        act_none,
        act_fill,
        act_pass_write,
        act_write_back
    } cache_action_e;

    // address bit 17 set means the I/O region, never cached
    localparam int UNCACHED_BIT = 17;
    localparam int OFFSET_BITS  = 2;

    // pick the addressed byte or halfword and extend it
    function automatic word_t load_extract(word_t data, logic [OFFSET_BITS-1:0] offset,
                                           size_e size, logic is_signed);
        byte_t b;
        half_t h;
        word_t result;
        b = data[8*offset +: 8];
        h = offset[1] ? data[31:16] : data[15:0];
        case (size)
            size_byte: result = {{24{b[7] & is_signed}}, b};
            size_half: result = {{16{h[15] & is_signed}}, h};
            default:   result = data;
        endcase
        return result;
    endfunction

    // narrow store data sits in the low bits of wdata
    function automatic word_t store_merge(word_t old, word_t wdata,
                                          logic [OFFSET_BITS-1:0] offset, size_e size);
        word_t result;
        result = old;
        case (size)
            size_byte: result[8*offset +: 8]     = wdata[7:0];
            size_half: result[16*offset[1] +: 16] = wdata[15:0];
            default:   result = wdata;
        endcase
        return result;
    endfunction

endpackage

//--- source/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
    import mem_pkg::*;

    // request, held steady while read or write is high
    logic  read;
    logic  write;
    size_e size;
    logic  is_signed;
    addr_t addr;
    word_t wdata;

    // answer, ready is a one-cycle pulse with rdata valid
    logic  ready;
    word_t rdata;

    modport requester (
        output read, write, size, is_signed, addr, wdata,
        input  ready, rdata
    );

    modport responder (
        input  read, write, size, is_signed, addr, wdata,
        output ready, rdata
    );

endinterface

//--- source/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic           clock,
    input  logic           reset,
    input  logic           req_valid_i,
    input  logic           req_write_i,
    input  mem_pkg::size_e req_size_i,
    input  logic           req_signed_i,
    input  mem_pkg::addr_t req_addr_i,
    input  mem_pkg::word_t req_wdata_i,
    output logic           busy_o,
    output logic           done_o,
    output mem_pkg::word_t rdata_o,
    mem_req_if.requester   bus
);
    import mem_pkg::*;

    logic  accept;
    logic  write_q;
    size_e size_q;
    logic  signed_q;
    addr_t addr_q;
    word_t wdata_q;

    // a pulse while an access is held is dropped
    assign accept = req_valid_i && !busy_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= busy_o && bus.ready;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (bus.ready) begin
                busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            write_q  <= req_write_i;
            size_q   <= req_size_i;
            signed_q <= req_signed_i;
            addr_q   <= req_addr_i;
            wdata_q  <= req_wdata_i;
        end
        if (busy_o && bus.ready) begin
            rdata_o <= bus.rdata;
        end
    end

    // request levels follow the held access
    assign bus.read      = busy_o && !write_q;
    assign bus.write     = busy_o && write_q;
    assign bus.size      = size_q;
    assign bus.is_signed = signed_q;
    assign bus.addr      = addr_q;
    assign bus.wdata     = wdata_q;

    // the cache may only see a stable request until it answers
    a_request_stable: assert property (@(posedge clock) disable iff (reset)
        (bus.read || bus.write) && !bus.ready |=>
            (bus.read || bus.write) && $stable(bus.addr) && $stable(bus.size)
            && $stable(bus.is_signed) && $stable(bus.wdata) && $stable(bus.write))
        else $error("request changed before ready");

endmodule

//--- source/data_cache.sv
`timescale 1ns/1ps

module data_cache #(
    parameter int CACHE_INDEX_BITS = 4
) (
    input  logic           clock,
    input  logic           reset,
    mem_req_if.responder   bus,
    input  logic           ram_busy_i,
    input  logic           ram_ready_i,
    input  mem_pkg::word_t ram_rdata_i,
    output logic           ram_read_o,
    output logic           ram_write_o,
    output mem_pkg::size_e ram_size_o,
    output logic           ram_signed_o,
    output mem_pkg::addr_t ram_addr_o,
    output mem_pkg::word_t ram_wdata_o
);
    import mem_pkg::*;

    localparam int LINES    = 2 ** CACHE_INDEX_BITS;
    localparam int TAG_BITS = 32 - CACHE_INDEX_BITS - OFFSET_BITS;

    typedef logic [CACHE_INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]         tag_t;

    // ==================================================
    // line storage
    // ==================================================
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    tag_t             tag_q  [LINES];
    word_t            data_q [LINES];

    index_t                 index;
    tag_t                   tag;
    logic [OFFSET_BITS-1:0] offset;
    word_t                  line;
    word_t                  line_wdata;
    logic                   uncached;
    logic                   hit;

    assign index      = bus.addr[OFFSET_BITS +: CACHE_INDEX_BITS];
    assign tag        = bus.addr[31 -: TAG_BITS];
    assign offset     = bus.addr[OFFSET_BITS-1:0];
    assign line       = data_q[index];
    assign uncached   = bus.addr[UNCACHED_BIT];
    assign hit        = !uncached && valid_q[index] && tag_q[index] == tag;
    // word stores replace the line while narrow ones merge into it
    assign line_wdata = store_merge(line, bus.wdata, offset, bus.size);

    // ==================================================
    // RAM transaction tracking
    // ==================================================
    logic delay_read_q;
    logic delay_write_q;
    logic delay_wb_q;
    logic fill_done;
    logic pass_done;
    logic wb_done;
    logic fill_line;

    assign fill_done = delay_read_q && ram_ready_i;
    assign wb_done   = delay_write_q && delay_wb_q && ram_ready_i;
    assign pass_done = delay_write_q && !delay_wb_q && ram_ready_i;
    // only cached word reads allocate since RAM returns narrow reads already extended
    assign fill_line = fill_done && !uncached && bus.size == size_word;

    // ==================================================
    // per-cycle decision
    // ==================================================
    cache_action_e action;
    logic          line_write;

    always_comb begin
        action     = act_none;
        line_write = 1'b0;
        bus.ready  = 1'b0;
        bus.rdata  = '0;
        if (bus.read) begin
            if (hit) begin
                bus.ready = 1'b1;
                bus.rdata = load_extract(line, offset, bus.size, bus.is_signed);
            end else if (fill_done) begin
                bus.ready = 1'b1;
                bus.rdata = ram_rdata_i;
            end else if (!uncached && dirty_q[index] && !wb_done) begin
                action = act_write_back;
            end else begin
                action = act_fill;
            end
        end else if (bus.write) begin
            if (hit) begin
                bus.ready  = 1'b1;
                line_write = 1'b1;
            end else if (uncached || bus.size != size_word) begin
                // narrow miss or I/O store goes straight to RAM
                if (pass_done) begin
                    bus.ready = 1'b1;
                end else begin
                    action = act_pass_write;
                end
            end else if (dirty_q[index] && !wb_done) begin
                action = act_write_back;
            end else begin
                bus.ready  = 1'b1;
                line_write = 1'b1;
            end
        end
    end

    // strobe goes out one cycle after the decision
    always_ff @(posedge clock) begin
        if (reset) begin
            delay_read_q  <= 1'b0;
            delay_write_q <= 1'b0;
            delay_wb_q    <= 1'b0;
        end else begin
            delay_read_q  <= action == act_fill;
            delay_write_q <= action inside {act_pass_write, act_write_back};
            delay_wb_q    <= action == act_write_back;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_write) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b1;
        end else if (fill_line) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (wb_done) begin
            dirty_q[index] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (line_write) begin
            tag_q[index]  <= tag;
            data_q[index] <= line_wdata;
        end else if (fill_line) begin
            tag_q[index]  <= tag;
            data_q[index] <= ram_rdata_i;
        end
    end

    // ==================================================
    // RAM bus
    // ==================================================
    assign ram_read_o   = delay_read_q && !ram_busy_i;
    assign ram_write_o  = delay_write_q && !ram_busy_i;
    // write-back targets the victim line as a whole word
    assign ram_addr_o   = delay_wb_q ? {tag_q[index], index, {OFFSET_BITS{1'b0}}} : bus.addr;
    assign ram_size_o   = delay_wb_q ? size_word : bus.size;
    assign ram_signed_o = bus.is_signed;
    assign ram_wdata_o  = delay_wb_q ? line : bus.wdata;

    a_one_strobe: assert property (@(posedge clock) disable iff (reset)
        !(ram_read_o && ram_write_o))
        else $error("RAM read and write strobes together");

    // the answer lasts one cycle because the requester drops its level after it
    a_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        bus.ready |=> !bus.ready)
        else $error("ready held for more than one cycle");

endmodule

//--- source/backing_memory.sv
`timescale 1ns/1ps

module backing_memory #(
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_ADDR_BITS = 12
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           ram_read_i,
    input  logic           ram_write_i,
    input  mem_pkg::size_e ram_size_i,
    input  logic           ram_signed_i,
    input  mem_pkg::addr_t ram_addr_i,
    input  mem_pkg::word_t ram_wdata_i,
    output logic           ram_busy_o,
    output logic           ram_ready_o,
    output mem_pkg::word_t ram_rdata_o
);
    import mem_pkg::*;

    localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);

    word_t mem [2 ** MEM_ADDR_BITS];

    logic [COUNT_BITS-1:0]    count_q;
    word_t                    rdata_q;
    logic [MEM_ADDR_BITS-1:0] word_addr;
    logic [OFFSET_BITS-1:0]   offset;
    logic                     accept;

    assign word_addr = ram_addr_i[OFFSET_BITS +: MEM_ADDR_BITS];
    assign offset    = ram_addr_i[OFFSET_BITS-1:0];
    assign accept    = (ram_read_i || ram_write_i) && !ram_busy_o;

    // ==================================================
    // latency counter
    // ==================================================
    // busy for MEM_LATENCY cycles, ready in the last one
    assign ram_busy_o  = count_q != '0;
    assign ram_ready_o = count_q == COUNT_BITS'(1);

    always_ff @(posedge clock) begin
        if (reset) begin
            count_q <= '0;
        end else if (accept) begin
            count_q <= COUNT_BITS'(MEM_LATENCY);
        end else if (ram_busy_o) begin
            count_q <= count_q - 1'b1;
        end
    end

    // ==================================================
    // storage
    // ==================================================
    // address and data are sampled on the accepting edge
    always_ff @(posedge clock) begin
        if (accept && ram_write_i) begin
            mem[word_addr] <= store_merge(mem[word_addr], ram_wdata_i, offset, ram_size_i);
        end
        if (accept && ram_read_i) begin
            rdata_q <= load_extract(mem[word_addr], offset, ram_size_i, ram_signed_i);
        end
    end

    assign ram_rdata_o = rdata_q;

    // the cache must hold its strobe off while busy
    a_no_strobe_when_busy: assert property (@(posedge clock) disable iff (reset)
        (ram_read_i || ram_write_i) |-> !ram_busy_o)
        else $error("RAM strobe while busy");

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int CACHE_INDEX_BITS = 4,
    parameter int MEM_LATENCY      = 3,
    parameter int MEM_ADDR_BITS    = 12
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           req_valid_i,
    input  logic           req_write_i,
    input  mem_pkg::size_e req_size_i,
    input  logic           req_signed_i,
    input  mem_pkg::addr_t req_addr_i,
    input  mem_pkg::word_t req_wdata_i,
    output logic           busy_o,
    output logic           done_o,
    output mem_pkg::word_t rdata_o
);
    import mem_pkg::*;

    mem_req_if req_bus ();

    // RAM strobe bus between cache and memory
    logic  ram_read;
    logic  ram_write;
    logic  ram_busy;
    logic  ram_ready;
    size_e ram_size;
    logic  ram_signed;
    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;

    load_store_unit u_lsu (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_size_i   (req_size_i),
        .req_signed_i (req_signed_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rdata_o      (rdata_o),
        .bus          (req_bus.requester)
    );

    data_cache #(
        .CACHE_INDEX_BITS (CACHE_INDEX_BITS)
    ) u_cache (
        .clock        (clock),
        .reset        (reset),
        .bus          (req_bus.responder),
        .ram_busy_i   (ram_busy),
        .ram_ready_i  (ram_ready),
        .ram_rdata_i  (ram_rdata),
        .ram_read_o   (ram_read),
        .ram_write_o  (ram_write),
        .ram_size_o   (ram_size),
        .ram_signed_o (ram_signed),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata)
    );

    backing_memory #(
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_memory (
        .clock        (clock),
        .reset        (reset),
        .ram_read_i   (ram_read),
        .ram_write_i  (ram_write),
        .ram_size_i   (ram_size),
        .ram_signed_i (ram_signed),
        .ram_addr_i   (ram_addr),
        .ram_wdata_i  (ram_wdata),
        .ram_busy_o   (ram_busy),
        .ram_ready_o  (ram_ready),
        .ram_rdata_o  (ram_rdata)
    );

endmodule

//--- tb/dcache_tb_model.svh
`ifndef DCACHE_TB_MODEL_SVH
`define DCACHE_TB_MODEL_SVH

// address set: 16 cached lines with four tags on each of four indexes,
// then 4 lines in the I/O region
localparam int CACHED_LINES = 16;
localparam int NUM_LINES    = 20;

logic [7:0]  ref_mem [NUM_LINES*4];
logic [31:0] lfsr_state;

// tags differ in bits 11:10, above the widest index
function automatic addr_t line_addr(input int line);
    addr_t addr;
    if (line < CACHED_LINES) begin
        addr = addr_t'((line % 4) << 2) | addr_t'((line / 4) << 10);
    end else begin
        // bit 12 keeps the I/O words apart from the cached ones in RAM
        addr = addr_t'(1 << UNCACHED_BIT) | addr_t'(1 << 12)
             | addr_t'((line - CACHED_LINES) << 2);
    end
    return addr;
endfunction

// little endian, narrow store data comes from the low bytes
function automatic void apply_store(input int line, input logic [1:0] offset,
                                    input size_e size, input word_t wdata);
    for (int i = 0; i < int'(size); i++) begin
        ref_mem[line*4 + int'(offset) + i] = wdata[8*i +: 8];
    end
endfunction

function automatic word_t expected_load(input int line, input logic [1:0] offset,
                                        input size_e size, input logic sgn);
    word_t result;
    int    base;
    result = '0;
    base   = line * 4 + int'(offset);
    for (int i = 0; i < int'(size); i++) begin
        result[8*i +: 8] = ref_mem[base + i];
    end
    // sign comes from the top byte that was read
    if (sgn && size != size_word && result[8*int'(size)-1]) begin
        result = result | (32'hffff_ffff << (8 * int'(size)));
    end
    return result;
endfunction

// ==================================================
// Fibonacci LFSR, taps 32 22 2 1
// ==================================================
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// one step per bit taken
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        result     = {result[30:0], lfsr_state[0]};
    end
    return result;
endfunction

`endif

//--- tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import mem_pkg::*;

    localparam int CACHE_INDEX_BITS  = 4;
    localparam int MEM_LATENCY       = 3;
    localparam int MEM_ADDR_BITS     = 12;
    localparam int DIRECTED_ACCESSES = 21;
    localparam int RANDOM_ACCESSES   = 400;

    `include "dcache_tb_model.svh"

    localparam int NUM_ACCESSES    = NUM_LINES + DIRECTED_ACCESSES + RANDOM_ACCESSES;
    // worst access is a write-back followed by a fill
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * (3 * MEM_LATENCY + 8) + 20;

    logic  clock;
    logic  reset;
    logic  req_valid_i;
    logic  req_write_i;
    size_e req_size_i;
    logic  req_signed_i;
    addr_t req_addr_i;
    word_t req_wdata_i;
    logic  busy_o;
    logic  done_o;
    word_t rdata_o;

    // the access in flight as the checker expects it
    logic  pending;
    logic  issued_any;
    logic  exp_load;
    word_t exp_data;
    addr_t exp_addr;
    int    errors;

    dcache_top #(
        .CACHE_INDEX_BITS (CACHE_INDEX_BITS),
        .MEM_LATENCY      (MEM_LATENCY),
        .MEM_ADDR_BITS    (MEM_ADDR_BITS)
    ) dut (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_size_i   (req_size_i),
        .req_signed_i (req_signed_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rdata_o      (rdata_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ==================================================
    // failure reporting and compare tasks
    // ==================================================
    task automatic stop_on_failure();
        errors++;
        $display("Errors found");
        $fatal(1, "run stopped at the first failing check");
    endtask

    task automatic describe_failure(input string msg);
        $display("%0t ns: %s", $time, msg);
        stop_on_failure();
    endtask

    task automatic check_word(input word_t got, input word_t expected, input addr_t addr);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: load from %h returned %h, expected %h",
                     $time, addr, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_done(input logic done, input logic outstanding);
        if (done && !issued_any) begin
            describe_failure("done_o rose before any request was issued");
        end else if (done && !outstanding) begin
            describe_failure("a second done_o followed a single request");
        end
    endtask

    // outputs are sampled mid-cycle well clear of both edges
    always @(negedge clock) begin
        if (!reset) begin
            check_done(done_o, pending);
            if (done_o) begin
                if (exp_load) begin
                    check_word(rdata_o, exp_data, exp_addr);
                end
                pending = 1'b0;
            end
            if (busy_o && !pending) begin
                describe_failure("busy_o is high while no access is outstanding");
            end
        end
    end

    // ==================================================
    // stimulus
    // ==================================================
    task automatic do_access(input logic write, input size_e size, input logic sgn,
                             input int line, input logic [1:0] offset, input word_t wdata);
        addr_t addr;
        addr = line_addr(line) | addr_t'(offset);
        @(posedge clock);
        #1;
        exp_load = !write;
        exp_addr = addr;
        exp_data = write ? '0 : expected_load(line, offset, size, sgn);
        if (write) begin
            apply_store(line, offset, size, wdata);
        end
        issued_any   = 1'b1;
        pending      = 1'b1;
        req_valid_i  = 1'b1;
        req_write_i  = write;
        req_size_i   = size;
        req_signed_i = sgn;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        @(posedge clock);
        #1;
        req_valid_i = 1'b0;
        while (pending) begin
            @(posedge clock);
        end
    endtask

    task automatic random_access();
        int         line;
        size_e      size;
        logic [1:0] offset;
        logic       write;
        logic       sgn;
        line = int'(take_bits(5) % NUM_LINES);
        case (take_bits(2))
            32'd0:   size = size_byte;
            32'd1:   size = size_half;
            default: size = size_word;
        endcase
        // accesses stay aligned to their size
        offset = 2'(take_bits(2));
        if (size == size_half) begin
            offset[0] = 1'b0;
        end else if (size == size_word) begin
            offset = 2'd0;
        end
        write = take_bits(1) != 0;
        sgn   = take_bits(1) != 0;
        do_access(write, size, sgn, line, offset, take_bits(32));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        describe_failure("watchdog expired before all accesses completed");
    end

    initial begin
        int conflict_reads [5];
        conflict_reads = '{2, 14, 2, 10, 6};
        reset        = 1'b1;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_size_i   = size_word;
        req_signed_i = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        pending      = 1'b0;
        issued_any   = 1'b0;
        exp_load     = 1'b0;
        exp_data     = '0;
        exp_addr     = '0;
        errors       = 0;
        lfsr_state   = 32'h4188;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        // every byte gets written once and loads never see reset contents
        for (int i = 0; i < NUM_LINES; i++) begin
            do_access(1'b1, size_word, 1'b0, i, 2'd0, take_bits(32));
        end

        // word store followed by hitting loads of the same word
        do_access(1'b1, size_word, 1'b0, 1, 2'd0, take_bits(32));
        do_access(1'b0, size_word, 1'b0, 1, 2'd0, '0);
        do_access(1'b0, size_byte, 1'b1, 1, 2'd3, '0);
        do_access(1'b0, size_half, 1'b0, 1, 2'd2, '0);

        // narrow stores merge into the cached line
        do_access(1'b1, size_byte, 1'b0, 1, 2'd1, take_bits(32));
        do_access(1'b1, size_half, 1'b0, 1, 2'd2, take_bits(32));
        do_access(1'b0, size_word, 1'b0, 1, 2'd0, '0);

        // four tags on index 2 written and then read back alternately
        for (int k = 0; k < 4; k++) begin
            do_access(1'b1, size_word, 1'b0, 2 + 4 * k, 2'd0, take_bits(32));
        end
        for (int k = 0; k < 5; k++) begin
            do_access(1'b0, size_word, 1'b0, conflict_reads[k], 2'd0, '0);
        end

        // I/O line 16 shares index 0 with a freshly written cached line
        do_access(1'b1, size_word, 1'b0, 0, 2'd0, take_bits(32));
        do_access(1'b0, size_word, 1'b0, 16, 2'd0, '0);
        do_access(1'b1, size_byte, 1'b0, 16, 2'd2, take_bits(32));
        do_access(1'b0, size_byte, 1'b1, 16, 2'd2, '0);
        do_access(1'b0, size_word, 1'b0, 0, 2'd0, '0);

        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            random_access();
        end

        repeat (4) @(posedge clock);
        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

//--- files.f
+incdir+tb
source/mem_pkg.sv
source/mem_req_if.sv
source/load_store_unit.sv
source/data_cache.sv
source/backing_memory.sv
source/dcache_top.sv
tb/dcache_tb.sv

//--- Makefile
# Verilator build for the data cache testbench

VERILATOR  ?= verilator
TOP        ?= dcache_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# the log decides pass or fail, not the simulator's exit status
sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
